// File: Makefile
TOP := tb_cvita_rx_frontend

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: design/axi_flop_stage.sv
// ======================================================================
// Stream register slice
// One-entry valid/ready stage, full throughput under continuous ready
// ======================================================================
`timescale 1ns/1ps

module axi_flop_stage #(
  parameter int WIDTH = 65
) (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_clear,
  // Upstream side
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  output logic             o_ready,
  // Downstream side
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid,
  input  logic             i_ready
);

  logic             full;
  logic [WIDTH-1:0] data_q;

  // Room when empty, or when the held beat leaves this cycle
  assign o_ready = ~full | i_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (i_clear) begin
      full <= 1'b0;  // Held beat is dropped
    end else if (o_ready) begin
      full <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_ready && i_valid) begin
      data_q <= i_data;
    end
  end

  assign o_data  = data_q;
  assign o_valid = full;

  // A stalled beat must stay put until the sink takes it
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!i_arst_n || i_clear)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
  );

endmodule

// File: design/cvita_hdr_parser.sv
// ======================================================================
// CVITA header parser
// Optional register stage, then header and VITA time split into fields
// with single-cycle strobes at the output transfer
// ======================================================================
`timescale 1ns/1ps

module cvita_hdr_parser #(
  parameter int REGISTER = 1  // 1 keeps fields valid for the whole packet
) (
  input  logic                                clk,
  input  logic                                i_arst_n,
  input  logic                                i_clear,
  // Input stream
  input  logic [cvita_pkg::BEAT_W-1:0]        i_tdata,
  input  logic                                i_tlast,
  input  logic                                i_tvalid,
  output logic                                o_tready,
  // Output stream
  output logic [cvita_pkg::BEAT_W-1:0]        o_tdata,
  output logic                                o_tlast,
  output logic                                o_tvalid,
  input  logic                                i_tready,
  // Header fields
  output logic                                o_hdr_stb,
  output cvita_pkg::pkt_type_e                o_pkt_type,
  output logic                                o_eob,
  output logic                                o_has_time,
  output logic [rx_status_pkg::SEQ_W-1:0]     o_seqnum,
  output logic [cvita_pkg::LEN_W-1:0]         o_pkt_len,
  output logic [cvita_pkg::SID_W-1:0]         o_sid,
  // VITA time
  output logic                                o_vita_time_stb,
  output logic [cvita_pkg::TIME_W-1:0]        o_vita_time
);

  logic                         beat_xfer;
  logic                         first_line;  // Next output beat is a header
  logic                         read_time;   // Next output beat is the time
  logic [cvita_pkg::BEAT_W-1:0] hdr_reg;
  logic [cvita_pkg::TIME_W-1:0] time_reg;
  logic [cvita_pkg::BEAT_W-1:0] hdr;

  generate
    if (REGISTER != 0) begin : g_reg
      axi_flop_stage #(
        .WIDTH(cvita_pkg::BEAT_W + 1)
      ) u_axi_flop_stage (
        .clk     (clk),
        .i_arst_n(i_arst_n),
        .i_clear (i_clear),
        .i_data  ({i_tlast, i_tdata}),
        .i_valid (i_tvalid),
        .o_ready (o_tready),
        .o_data  ({o_tlast, o_tdata}),
        .o_valid (o_tvalid),
        .i_ready (i_tready)
      );
    end else begin : g_pass
      assign o_tdata  = i_tdata;
      assign o_tlast  = i_tlast;
      assign o_tvalid = i_tvalid;
      assign o_tready = i_tready;
    end
  endgenerate

  assign beat_xfer = o_tvalid & i_tready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      first_line <= 1'b1;
      read_time  <= 1'b0;
    end else if (i_clear) begin
      first_line <= 1'b1;
      read_time  <= 1'b0;
    end else if (beat_xfer) begin
      if (first_line) begin
        first_line <= o_tlast;  // Header-only packet starts over
        read_time  <= o_tdata[cvita_pkg::HAS_TIME_BIT] & ~o_tlast;
      end else begin
        read_time <= 1'b0;
        if (o_tlast) begin
          first_line <= 1'b1;
        end
      end
    end
  end

  // Held copies for the rest of the packet
  always_ff @(posedge clk) begin
    if (o_hdr_stb) begin
      hdr_reg <= o_tdata;
    end
    if (o_vita_time_stb) begin
      time_reg <= o_tdata;
    end
  end

  assign o_hdr_stb       = first_line & beat_xfer;
  assign o_vita_time_stb = read_time & beat_xfer;

  // Live beat during the strobe, held copy afterwards
  assign hdr         = (o_hdr_stb || REGISTER == 0) ? o_tdata : hdr_reg;
  assign o_vita_time = (o_vita_time_stb || REGISTER == 0) ? o_tdata : time_reg;

  assign o_pkt_type = cvita_pkg::pkt_type_e'(hdr[cvita_pkg::TYPE_LSB +: cvita_pkg::TYPE_W]);
  assign o_eob      = hdr[cvita_pkg::EOB_BIT];
  assign o_has_time = hdr[cvita_pkg::HAS_TIME_BIT];
  assign o_seqnum   = hdr[cvita_pkg::SEQ_LSB +: rx_status_pkg::SEQ_W];
  assign o_pkt_len  = hdr[cvita_pkg::LEN_LSB +: cvita_pkg::LEN_W];
  assign o_sid      = hdr[cvita_pkg::SID_LSB +: cvita_pkg::SID_W];

  // Header and time beats are distinct transfers
  a_stb_excl : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !(o_hdr_stb && o_vita_time_stb)
  );

endmodule

// File: design/cvita_pkg.sv
// ======================================================================
// CVITA packet format
// Beat width, header field widths and positions, packet type encoding
// ======================================================================
package cvita_pkg;

  localparam int BEAT_W = 64;  // One stream beat
  localparam int LEN_W  = 16;  // Packet length in bytes
  localparam int SID_W  = 32;
  localparam int TIME_W = 64;

  // Header field positions, low bit of each field
  localparam int TYPE_LSB     = 62;
  localparam int EOB_BIT      = 61;
  localparam int HAS_TIME_BIT = 60;
  localparam int SEQ_LSB      = 48;
  localparam int LEN_LSB      = 32;
  localparam int SID_LSB      = 0;

  typedef enum logic [1:0] {
    PKT_DATA = 2'd0,
    PKT_FC   = 2'd1,  // Flow control
    PKT_CMD  = 2'd2,
    PKT_RESP = 2'd3
  } pkt_type_e;

  localparam int TYPE_W = $bits(pkt_type_e);

endpackage

// File: design/cvita_pkt_checker.sv
// ======================================================================
// CVITA packet checker
// Sequence continuity and beat count against the length field,
// one result strobe per packet
// ======================================================================
`timescale 1ns/1ps

module cvita_pkt_checker (
  input  logic                            clk,
  input  logic                            i_arst_n,
  input  logic                            i_clear,
  input  logic                            i_beat_stb,  // Output transfer
  input  logic                            i_last,
  input  logic                            i_hdr_stb,
  input  logic [rx_status_pkg::SEQ_W-1:0] i_seqnum,
  input  logic [cvita_pkg::LEN_W-1:0]     i_pkt_len,
  input  logic                            i_has_time,
  output logic                            o_res_stb,
  output rx_status_pkg::pkt_result_e      o_res_code
);

  logic                            pkt_open;
  logic                            seq_valid;  // Set once a packet has been seen
  logic [rx_status_pkg::SEQ_W-1:0] exp_seq;
  logic [cvita_pkg::LEN_W-1:0]     beat_cnt;
  logic [cvita_pkg::LEN_W-1:0]     exp_beats;
  logic                            seq_err_q;

  logic [cvita_pkg::LEN_W:0]       len_round;
  logic [cvita_pkg::LEN_W-1:0]     hdr_beats;
  logic                            hdr_seq_err;
  logic [cvita_pkg::LEN_W-1:0]     cur_cnt;
  logic [cvita_pkg::LEN_W-1:0]     cur_exp;
  logic                            cur_seq_err;
  logic                            cur_len_err;

  // Bytes rounded up to 8-byte beats, header included
  assign len_round   = {1'b0, i_pkt_len} + (cvita_pkg::LEN_W + 1)'(7);
  assign hdr_beats   = cvita_pkg::LEN_W'(len_round >> 3);
  assign hdr_seq_err = seq_valid && (i_seqnum != exp_seq);

  // The header beat may also be the last one
  assign cur_cnt     = i_hdr_stb ? cvita_pkg::LEN_W'(1) : beat_cnt + 1'b1;
  assign cur_exp     = i_hdr_stb ? hdr_beats : exp_beats;
  assign cur_seq_err = i_hdr_stb ? hdr_seq_err : seq_err_q;
  assign cur_len_err = (cur_cnt != cur_exp);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pkt_open  <= 1'b0;
      seq_valid <= 1'b0;
      beat_cnt  <= '0;
      o_res_stb <= 1'b0;
    end else if (i_clear) begin
      pkt_open  <= 1'b0;
      seq_valid <= 1'b0;
      beat_cnt  <= '0;
      o_res_stb <= 1'b0;
    end else begin
      o_res_stb <= i_beat_stb & i_last;
      if (i_beat_stb) begin
        beat_cnt <= cur_cnt;
        pkt_open <= ~i_last;
      end
      if (i_hdr_stb) begin
        seq_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_hdr_stb) begin
      exp_seq   <= i_seqnum + 1'b1;  // Resync on mismatch too
      exp_beats <= hdr_beats;
      seq_err_q <= hdr_seq_err;
    end
    if (i_beat_stb && i_last) begin
      o_res_code <= rx_status_pkg::pkt_result_e'({cur_len_err, cur_seq_err});
    end
  end

  // A header never lands inside an open packet
  a_hdr_closed : assert property (
    @(posedge clk) disable iff (!i_arst_n || i_clear)
    i_hdr_stb |-> (!pkt_open && i_beat_stb)
  );

endmodule

// File: design/cvita_rx_frontend.sv
// ======================================================================
// CVITA receive front end
// Header parser with optional register stage and per-packet checker
// ======================================================================
`timescale 1ns/1ps

module cvita_rx_frontend #(
  parameter int REGISTER = 1
) (
  input  logic                            clk,
  input  logic                            i_arst_n,
  input  logic                            i_clear,
  // Stream from source
  input  logic [cvita_pkg::BEAT_W-1:0]    i_tdata,
  input  logic                            i_tlast,
  input  logic                            i_tvalid,
  output logic                            o_tready,
  // Stream to sink
  output logic [cvita_pkg::BEAT_W-1:0]    o_tdata,
  output logic                            o_tlast,
  output logic                            o_tvalid,
  input  logic                            i_tready,
  // Header and time fields
  output logic                            o_hdr_stb,
  output cvita_pkg::pkt_type_e            o_pkt_type,
  output logic                            o_eob,
  output logic                            o_has_time,
  output logic [rx_status_pkg::SEQ_W-1:0] o_seqnum,
  output logic [cvita_pkg::LEN_W-1:0]     o_pkt_len,
  output logic [cvita_pkg::SID_W-1:0]     o_sid,
  output logic                            o_vita_time_stb,
  output logic [cvita_pkg::TIME_W-1:0]    o_vita_time,
  // Packet report
  output logic                            o_res_stb,
  output rx_status_pkg::pkt_result_e      o_res_code
);

  logic beat_stb;

  assign beat_stb = o_tvalid & i_tready;  // Checker watches output transfers

  cvita_hdr_parser #(
    .REGISTER(REGISTER)
  ) u_cvita_hdr_parser (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_clear        (i_clear),
    .i_tdata        (i_tdata),
    .i_tlast        (i_tlast),
    .i_tvalid       (i_tvalid),
    .o_tready       (o_tready),
    .o_tdata        (o_tdata),
    .o_tlast        (o_tlast),
    .o_tvalid       (o_tvalid),
    .i_tready       (i_tready),
    .o_hdr_stb      (o_hdr_stb),
    .o_pkt_type     (o_pkt_type),
    .o_eob          (o_eob),
    .o_has_time     (o_has_time),
    .o_seqnum       (o_seqnum),
    .o_pkt_len      (o_pkt_len),
    .o_sid          (o_sid),
    .o_vita_time_stb(o_vita_time_stb),
    .o_vita_time    (o_vita_time)
  );

  cvita_pkt_checker u_cvita_pkt_checker (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_clear   (i_clear),
    .i_beat_stb(beat_stb),
    .i_last    (o_tlast),
    .i_hdr_stb (o_hdr_stb),
    .i_seqnum  (o_seqnum),
    .i_pkt_len (o_pkt_len),
    .i_has_time(o_has_time),
    .o_res_stb (o_res_stb),
    .o_res_code(o_res_code)
  );

endmodule

// File: design/rx_status_pkg.sv
// ======================================================================
// Receive check results
// Sequence number width and the per-packet result code
// ======================================================================
package rx_status_pkg;

  localparam int SEQ_W = 12;  // Wraps modulo 4096

  // Encoded as {length error, sequence error}
  typedef enum logic [1:0] {
    RES_OK       = 2'b00,
    RES_SEQ_ERR  = 2'b01,
    RES_LEN_ERR  = 2'b10,
    RES_BOTH_ERR = 2'b11
  } pkt_result_e;

endpackage

// File: sources.f
design/cvita_pkg.sv
design/rx_status_pkg.sv
design/axi_flop_stage.sv
design/cvita_hdr_parser.sv
design/cvita_pkt_checker.sv
design/cvita_rx_frontend.sv
test/tb_clkgen.sv
test/tb_cvita_rx_frontend.sv

// File: test/tb_clkgen.sv
// ======================================================================
// Testbench clock source
// Free-running clock, 4 ns period
// ======================================================================
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int HALF_NS = 2
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

endmodule

// File: test/tb_cvita_rx_frontend.sv
// ======================================================================
// CVITA receive front end testbench
// Random back-pressure, sequence and length faults, clear mid-packet
// ======================================================================
`timescale 1ns/1ps

module tb_cvita_rx_frontend;

  localparam int MAX_CYCLES = 20000;  // ~200 packets of up to 40 beats at half rate

  logic                       clk;
  logic                       i_arst_n;
  logic                       i_clear;
  logic [63:0]                i_tdata;
  logic                       i_tlast;
  logic                       i_tvalid;
  logic                       o_tready;
  logic [63:0]                o_tdata;
  logic                       o_tlast;
  logic                       o_tvalid;
  logic                       i_tready;
  logic                       o_hdr_stb;
  cvita_pkg::pkt_type_e       o_pkt_type;
  logic                       o_eob;
  logic                       o_has_time;
  logic [11:0]                o_seqnum;
  logic [15:0]                o_pkt_len;
  logic [31:0]                o_sid;
  logic                       o_vita_time_stb;
  logic [63:0]                o_vita_time;
  logic                       o_res_stb;
  rx_status_pkg::pkt_result_e o_res_code;

  // Expected traffic filled as packets are sent
  logic [64:0]                exp_beat_q[$];  // {last, data}
  logic [63:0]                exp_hdr_q[$];
  logic [63:0]                exp_time_q[$];
  rx_status_pkg::pkt_result_e exp_res_q[$];
  logic [64:0]                exp_beat;
  logic [63:0]                exp_hdr;
  logic [63:0]                exp_time;
  bit                         seq_seen;
  logic [11:0]                seq_next;
  bit                         hdr_seen;
  bit                         time_seen;
  int                         cycle_cnt = 0;

  tb_clkgen u_tb_clkgen (.o_clk(clk));

  cvita_rx_frontend #(.REGISTER(1)) u_cvita_rx_frontend (.*);

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [64:0] got, input logic [64:0] exp);
    assert (got === exp)
      else end_with_failure($sformatf("[FAIL] %s got=0x%0h expected=0x%0h", name, got, exp));
  endtask

  function automatic rx_status_pkg::pkt_result_e expected_result(input bit seq_bad,
                                                                 input bit len_bad);
    if (seq_bad && len_bad) begin
      return rx_status_pkg::RES_BOTH_ERR;
    end else if (len_bad) begin
      return rx_status_pkg::RES_LEN_ERR;
    end else if (seq_bad) begin
      return rx_status_pkg::RES_SEQ_ERR;
    end else begin
      return rx_status_pkg::RES_OK;
    end
  endfunction

  // Holds one beat on the input until the DUT takes it
  task automatic drive_beat(input logic [63:0] data, input logic last);
    bit taken;
    i_tdata  = data;
    i_tlast  = last;
    i_tvalid = 1'b1;
    do begin
      @(negedge clk);
      taken = o_tready;  // Ready mid-cycle decides the coming edge
      @(posedge clk);
    end while (!taken);
    #1;
  endtask

  // len_skew moves the length field by whole beats
  // Fewer beats sent than n_beats leaves the packet cut
  task automatic send_packet(input logic [11:0] seq, input int n_beats, input bit has_time,
                             input int len_skew, input int n_send);
    logic [63:0] hdr;
    logic [63:0] beat;
    int          len_bytes;
    int          gap;
    bit          seq_bad;
    bit          len_bad;
    len_bytes   = 8 * (n_beats + len_skew) - int'($urandom_range(0, 7));
    hdr         = {$urandom(), $urandom()};
    hdr[60]     = has_time;
    hdr[59:48]  = seq;
    hdr[47:32]  = len_bytes[15:0];
    seq_bad     = seq_seen && (seq != seq_next);
    len_bad     = ((len_bytes + 7) / 8) != n_beats;
    seq_seen    = 1'b1;
    seq_next    = seq + 12'd1;
    exp_hdr_q.push_back(hdr);
    for (int i = 0; i < n_send; i++) begin
      beat = (i == 0) ? hdr : {$urandom(), $urandom()};
      if (i == 1 && has_time) exp_time_q.push_back(beat);  // Second beat carries the time
      exp_beat_q.push_back({i == n_beats - 1, beat});
      drive_beat(beat, i == n_beats - 1);
    end
    if (n_send == n_beats) begin
      exp_res_q.push_back(expected_result(seq_bad, len_bad));
    end
    i_tvalid = 1'b0;
    gap = int'($urandom_range(0, 2));
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      end_with_failure("Simulation timed out before all packets were checked");
    end
  end

  // Strobes seen mid-cycle belong to the coming edge
  always @(negedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hdr_seen  <= 1'b0;
      time_seen <= 1'b0;
    end else begin
      if (o_hdr_stb) hdr_seen <= 1'b1;
      if (o_vita_time_stb) time_seen <= 1'b1;
    end
  end

  // Scoreboard at output transfers and strobes
  always @(negedge clk) begin
    if (i_arst_n && o_tvalid && i_tready) begin
      if (exp_beat_q.size() == 0) begin
        end_with_failure("An output beat came out with no input beat waiting for it");
      end else begin
        exp_beat = exp_beat_q.pop_front();
        check_value("o_tdata", 65'(o_tdata), 65'(exp_beat[63:0]));
        check_value("o_tlast", 65'(o_tlast), 65'(exp_beat[64]));
      end
    end
    if (i_arst_n && o_hdr_stb) begin
      if (exp_hdr_q.size() == 0) begin
        end_with_failure("A header strobe fired with no packet expected");
      end else begin
        exp_hdr = exp_hdr_q.pop_front();
        check_value("o_pkt_type", 65'(o_pkt_type), 65'(exp_hdr[63:62]));
        check_value("o_eob", 65'(o_eob), 65'(exp_hdr[61]));
        check_value("o_has_time", 65'(o_has_time), 65'(exp_hdr[60]));
        check_value("o_seqnum", 65'(o_seqnum), 65'(exp_hdr[59:48]));
        check_value("o_pkt_len", 65'(o_pkt_len), 65'(exp_hdr[47:32]));
        check_value("o_sid", 65'(o_sid), 65'(exp_hdr[31:0]));
      end
    end
    if (i_arst_n && o_vita_time_stb) begin
      if (exp_time_q.size() == 0) begin
        end_with_failure("A time strobe fired for a packet without a time beat");
      end else begin
        exp_time = exp_time_q.pop_front();
        check_value("o_vita_time", 65'(o_vita_time), 65'(exp_time));
      end
    end
    if (i_arst_n && o_res_stb) begin
      if (exp_res_q.size() == 0) begin
        end_with_failure("A packet result arrived with no complete packet expected");
      end else begin
        check_value("o_res_code", 65'(o_res_code), 65'(exp_res_q.pop_front()));
      end
    end
  end

  a_res_after_last : assert property (
    @(posedge clk) disable iff (!i_arst_n || i_clear)
    (o_tvalid && i_tready && o_tlast) |=> o_res_stb
  ) else end_with_failure("Result strobe missing one cycle after a last beat");

  a_res_only_after_last : assert property (
    @(posedge clk) disable iff (!i_arst_n || i_clear)
    o_res_stb |-> $past(o_tvalid && i_tready && o_tlast)
  ) else end_with_failure("Result strobe fired without a last beat the cycle before");

  a_fields_hold : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (hdr_seen && !o_hdr_stb) |->
      $stable({o_pkt_type, o_eob, o_has_time, o_seqnum, o_pkt_len, o_sid})
  ) else end_with_failure("Header fields changed between header strobes");

  a_time_hold : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (time_seen && !o_vita_time_stb) |-> $stable(o_vita_time)
  ) else end_with_failure("VITA time changed between time strobes");

  a_time_needs_flag : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    o_vita_time_stb |-> o_has_time
  ) else end_with_failure("Time strobe fired for a header without the has-time bit");

  initial begin
    int          n;
    logic [11:0] seq;
    i_arst_n = 1'b0;
    i_clear  = 1'b0;
    i_tdata  = '0;
    i_tlast  = 1'b0;
    i_tvalid = 1'b0;
    i_tready = 1'b0;
    void'($urandom(32'h26be));
    fork
      forever begin  // Sink ready about half the cycles
        @(posedge clk);
        #1;
        i_tready = ($urandom_range(0, 1) == 1);
      end
    join_none
    repeat (2) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    assert (!o_tvalid && !o_hdr_stb && !o_vita_time_stb && !o_res_stb && o_tready)
      else end_with_failure("Outputs were not in their reset state after reset");

    seq = 12'hfa0;  // Wraps past 4095 during the random run
    for (int k = 0; k < 150; k++) begin
      n = int'($urandom_range(1, 40));
      send_packet(seq, n, $urandom_range(0, 1) == 1, 0, n);
      seq = seq + 12'd1;
    end

    // Skipped and then repeated sequence number with a good packet after each
    send_packet(seq + 12'd2, 4, 1'b1, 0, 4);
    send_packet(seq + 12'd3, 3, 1'b0, 0, 3);
    send_packet(seq + 12'd3, 5, 1'b0, 0, 5);
    send_packet(seq + 12'd4, 2, 1'b1, 0, 2);
    seq = seq + 12'd5;

    // Length field too long, too short, and with a sequence skip
    send_packet(seq, 6, 1'b1, 1, 6);
    send_packet(seq + 12'd1, 6, 1'b0, -1, 6);
    send_packet(seq + 12'd3, 1, 1'b0, 1, 1);
    send_packet(seq + 12'd4, 3, 1'b0, 0, 3);
    seq = seq + 12'd5;

    // Clear once a cut packet has drained
    send_packet(seq, 10, 1'b1, 0, 3);
    while (exp_beat_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    i_clear = 1'b1;
    @(posedge clk);
    #1;
    i_clear  = 1'b0;
    seq_seen = 1'b0;
    send_packet(seq + 12'd100, 4, 1'b0, 0, 4);
    send_packet(seq + 12'd101, 3, 1'b1, 0, 3);
    seq = seq + 12'd102;

    for (int k = 0; k < 30; k++) begin
      n = int'($urandom_range(1, 40));
      send_packet(seq, n, $urandom_range(0, 1) == 1, 0, n);
      seq = seq + 12'd1;
    end

    while (exp_res_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    if (exp_beat_q.size() != 0 || exp_hdr_q.size() != 0 || exp_time_q.size() != 0) begin
      end_with_failure("Some expected beats, headers or times never came out");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
